/* Bender.yml */
package:
  name: tmr_regfile

export_include_dirs:
  - design

sources:
  - files:
      - design/tmr_pkg.sv
      - design/seu_reg_we.sv
      - design/tmr_voter.sv
      - design/wr_credit_queue.sv
      - design/tmr_reg_file.sv
      - design/tmr_scrubber.sv
      - design/tmr_regfile_top.sv
  - target: test
    files:
      - test/clk_gen.sv
      - test/tb_tmr_regfile.sv

/* design/seu_reg_we.sv */
// seu_reg_we: triplicated write-enabled register with per-copy upset masks
`timescale 1ns/100ps
`include "tmr_defines.svh"

module seu_reg_we import tmr_pkg::*; #(
    parameter type T = word_t
) (
    input  logic s_c_i,
    input  logic rst_n_i,
    input  logic we_i,
    input  T     d_i,
    input  T     upset_i [3],
    output T     q_o [3]
);

    localparam T RST_VAL = T'(`TMR_RST_VAL);

    T r_copy [3];

    assign q_o = r_copy;

    // each copy has its own flop, so one copy can be hit without the others
    for (genvar c = 0; c < 3; c++) begin : g_copy
        always_ff @(posedge s_c_i) begin
            if (!rst_n_i) begin
                r_copy[c] <= RST_VAL;
            end else if (we_i) begin
                r_copy[c] <= d_i ^ upset_i[c];  // injected bits land on new data
            end else begin
                r_copy[c] <= r_copy[c] ^ upset_i[c];  // upset flips held value
            end
        end
    end

endmodule

/* design/tmr_defines.svh */
// word width, depth, write queue depth and reset value macros for the TMR register file
`ifndef TMR_DEFINES_SVH
`define TMR_DEFINES_SVH

// data word width in bits
`define TMR_WIDTH 32

// number of stored words, a power of two
`define TMR_DEPTH 16

// write queue entries; the sender starts with this many credits
`define TMR_WQ_DEPTH 4

// value every copy takes on reset
`define TMR_RST_VAL 0

`endif

/* design/tmr_pkg.sv */
// tmr_pkg: word, address, copy index and write request types
`include "tmr_defines.svh"

package tmr_pkg;

    // one stored data word
    typedef logic [`TMR_WIDTH-1:0] word_t;

    // word address into the register file
    typedef logic [$clog2(`TMR_DEPTH)-1:0] addr_t;

    // copy index, 0 to 2 are valid
    typedef logic [1:0] copy_t;

    // one queued write
    typedef struct packed {
        addr_t addr;  // target word
        word_t data;  // value to store
    } wr_req_t;

endpackage

/* design/tmr_reg_file.sv */
// tmr_reg_file: addressed array of triplicated words with injection, voted read and scrub ports
`timescale 1ns/100ps
`include "tmr_defines.svh"

module tmr_reg_file import tmr_pkg::*; (
    input  logic  s_c_i,
    input  logic  rst_n_i,

    input  logic  we_i,
    input  addr_t wa_i,
    input  word_t wd_i,

    input  logic  inj_en_i,
    input  addr_t inj_addr_i,
    input  copy_t inj_copy_i,
    input  logic  inj_dual_i,
    input  word_t inj_mask_i,

    input  addr_t ra_i,
    output word_t rd_o,
    output logic  rd_err_o,

    input  addr_t sa_i,
    output word_t sd_o,
    output logic  s_err_o
);

    localparam int DEPTH = `TMR_DEPTH;

    word_t      words [DEPTH][3];  // all copies of all words
    word_t      upset [DEPTH][3];
    logic [2:0] inj_sel;           // copies hit by injection
    word_t      rd_vote;
    logic       rd_verr;

    // dual mode also hits the next copy, wrapping 2 -> 0
    always_comb begin
        case (inj_copy_i)
            2'd0:    inj_sel = inj_dual_i ? 3'b011 : 3'b001;
            2'd1:    inj_sel = inj_dual_i ? 3'b110 : 3'b010;
            2'd2:    inj_sel = inj_dual_i ? 3'b101 : 3'b100;
            default: inj_sel = 3'b000;
        endcase
    end

    for (genvar i = 0; i < DEPTH; i++) begin : g_word
        logic word_we;
        logic word_hit;

        assign word_we  = we_i && (wa_i == addr_t'(i));
        assign word_hit = inj_en_i && (inj_addr_i == addr_t'(i));

        for (genvar c = 0; c < 3; c++) begin : g_upset
            assign upset[i][c] = (word_hit && inj_sel[c]) ? inj_mask_i : '0;
        end

        seu_reg_we #(
            .T(word_t)
        ) u_word (
            .s_c_i  (s_c_i),
            .rst_n_i(rst_n_i),
            .we_i   (word_we),
            .d_i    (wd_i),
            .upset_i(upset[i]),
            .q_o    (words[i])
        );
    end

    tmr_voter #(
        .T(word_t)
    ) u_rd_voter (
        .a_i  (words[ra_i][0]),
        .b_i  (words[ra_i][1]),
        .c_i  (words[ra_i][2]),
        .y_o  (rd_vote),
        .err_o(rd_verr)
    );

    // scrub side stays combinational so the fix lands in the same cycle
    tmr_voter #(
        .T(word_t)
    ) u_scrub_voter (
        .a_i  (words[sa_i][0]),
        .b_i  (words[sa_i][1]),
        .c_i  (words[sa_i][2]),
        .y_o  (sd_o),
        .err_o(s_err_o)
    );

    always_ff @(posedge s_c_i) begin
        rd_o <= rd_vote;  // read data, one cycle after address
    end

    always_ff @(posedge s_c_i) begin
        if (!rst_n_i) begin
            rd_err_o <= 1'b0;
        end else begin
            rd_err_o <= rd_verr;
        end
    end

    a_inj_copy_range: assert property (@(posedge s_c_i) disable iff (!rst_n_i)
        inj_en_i |-> (inj_copy_i < 2'd3));

endmodule

/* design/tmr_regfile_top.sv */
// tmr_regfile_top: write queue, scrubber and register file with the write mux
`timescale 1ns/100ps
`include "tmr_defines.svh"

module tmr_regfile_top import tmr_pkg::*; (
    input  logic        s_c_i,
    input  logic        rst_n_i,

    input  logic        wr_valid_i,
    input  addr_t       wr_addr_i,
    input  word_t       wr_data_i,
    output logic        wr_credit_o,

    input  addr_t       rd_addr_i,
    output word_t       rd_data_o,
    output logic        rd_err_o,

    input  logic        inj_en_i,
    input  addr_t       inj_addr_i,
    input  copy_t       inj_copy_i,
    input  logic        inj_dual_i,
    input  word_t       inj_mask_i,

    output logic [15:0] corr_count_o
);

    wr_req_t push_req;
    logic    q_valid;
    wr_req_t q_req;
    logic    q_pop;
    addr_t   scrub_addr;
    word_t   scrub_data;
    logic    scrub_err;
    logic    corr_we;
    addr_t   corr_addr;
    word_t   corr_data;
    logic    rf_we;
    addr_t   rf_wa;
    word_t   rf_wd;

    assign push_req = '{addr: wr_addr_i, data: wr_data_i};

    // corrections win, the queue head waits a cycle
    assign q_pop = q_valid && !corr_we;
    assign rf_we = corr_we || q_pop;
    assign rf_wa = corr_we ? corr_addr : q_req.addr;
    assign rf_wd = corr_we ? corr_data : q_req.data;

    wr_credit_queue #(
        .T(wr_req_t)
    ) u_queue (
        .s_c_i      (s_c_i),
        .rst_n_i    (rst_n_i),
        .push_i     (wr_valid_i),
        .push_data_i(push_req),
        .pop_i      (q_pop),
        .valid_o    (q_valid),
        .data_o     (q_req),
        .credit_o   (wr_credit_o)
    );

    tmr_reg_file u_rf (
        .s_c_i     (s_c_i),
        .rst_n_i   (rst_n_i),
        .we_i      (rf_we),
        .wa_i      (rf_wa),
        .wd_i      (rf_wd),
        .inj_en_i  (inj_en_i),
        .inj_addr_i(inj_addr_i),
        .inj_copy_i(inj_copy_i),
        .inj_dual_i(inj_dual_i),
        .inj_mask_i(inj_mask_i),
        .ra_i      (rd_addr_i),
        .rd_o      (rd_data_o),
        .rd_err_o  (rd_err_o),
        .sa_i      (scrub_addr),
        .sd_o      (scrub_data),
        .s_err_o   (scrub_err)
    );

    tmr_scrubber u_scrub (
        .s_c_i       (s_c_i),
        .rst_n_i     (rst_n_i),
        .sd_i        (scrub_data),
        .s_err_i     (scrub_err),
        .sa_o        (scrub_addr),
        .corr_we_o   (corr_we),
        .corr_addr_o (corr_addr),
        .corr_data_o (corr_data),
        .corr_count_o(corr_count_o)
    );

endmodule

/* design/tmr_scrubber.sv */
// tmr_scrubber: background address sweep with correction writes and a correction counter
`timescale 1ns/100ps
`include "tmr_defines.svh"

module tmr_scrubber import tmr_pkg::*; (
    input  logic        s_c_i,
    input  logic        rst_n_i,
    input  word_t       sd_i,
    input  logic        s_err_i,
    output addr_t       sa_o,
    output logic        corr_we_o,
    output addr_t       corr_addr_o,
    output word_t       corr_data_o,
    output logic [15:0] corr_count_o
);

    localparam int DEPTH = `TMR_DEPTH;

    addr_t ptr_copy [3];  // pointer copies
    addr_t ptr_next;
    addr_t no_upset [3];

    assign no_upset = '{default: '0};

    // each copy reloads from the vote, so a hit on one heals next cycle
    assign ptr_next = (sa_o == addr_t'(DEPTH - 1)) ? '0 : addr_t'(sa_o + 1'b1);

    seu_reg_we #(
        .T(addr_t)
    ) u_ptr (
        .s_c_i  (s_c_i),
        .rst_n_i(rst_n_i),
        .we_i   (1'b1),
        .d_i    (ptr_next),
        .upset_i(no_upset),
        .q_o    (ptr_copy)
    );

    tmr_voter #(
        .T(addr_t)
    ) u_ptr_voter (
        .a_i  (ptr_copy[0]),
        .b_i  (ptr_copy[1]),
        .c_i  (ptr_copy[2]),
        .y_o  (sa_o),
        .err_o()              // pointer repairs itself
    );

    // voted word goes back into all three copies
    assign corr_we_o   = s_err_i;
    assign corr_addr_o = sa_o;
    assign corr_data_o = sd_i;

    always_ff @(posedge s_c_i) begin
        if (!rst_n_i) begin
            corr_count_o <= '0;
        end else if (corr_we_o && (corr_count_o != 16'hffff)) begin
            corr_count_o <= corr_count_o + 1'b1;  // saturates at all ones
        end
    end

endmodule

/* design/tmr_voter.sv */
// tmr_voter: bitwise two-of-three majority voter with disagreement flag
`timescale 1ns/100ps
`include "tmr_defines.svh"

module tmr_voter import tmr_pkg::*; #(
    parameter type T = word_t
) (
    input  T     a_i,
    input  T     b_i,
    input  T     c_i,
    output T     y_o,
    output logic err_o
);

    // per bit, any two equal copies win
    assign y_o = (a_i & b_i) | (a_i & c_i) | (b_i & c_i);

    // one compare per pair is enough, c vs b follows
    assign err_o = (a_i != b_i) || (a_i != c_i);

endmodule

/* design/wr_credit_queue.sv */
// wr_credit_queue: circular write request FIFO returning one credit per pop
`timescale 1ns/100ps
`include "tmr_defines.svh"

module wr_credit_queue import tmr_pkg::*; #(
    parameter type T = wr_req_t
) (
    input  logic s_c_i,
    input  logic rst_n_i,
    input  logic push_i,
    input  T     push_data_i,
    input  logic pop_i,
    output logic valid_o,
    output T     data_o,
    output logic credit_o
);

    localparam int DEPTH = `TMR_WQ_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full    = (count == CNT_W'(DEPTH));
    assign valid_o = (count != '0);
    assign data_o  = mem[rd_ptr];  // head entry
    assign do_push = push_i && !full;
    assign do_pop  = pop_i && valid_o;

    always_ff @(posedge s_c_i) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge s_c_i) begin
        if (!rst_n_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            credit_o <= do_pop;  // credit goes back once the entry has left
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // sender pushed without holding a credit
    a_no_push_full: assert property (@(posedge s_c_i) disable iff (!rst_n_i)
        push_i |-> !full);

    // the pop condition outside must respect the head valid
    a_no_pop_empty: assert property (@(posedge s_c_i) disable iff (!rst_n_i)
        pop_i |-> valid_o);

endmodule

/* sim.f */
+incdir+design
design/tmr_pkg.sv
design/seu_reg_we.sv
design/tmr_voter.sv
design/wr_credit_queue.sv
design/tmr_reg_file.sv
design/tmr_scrubber.sv
design/tmr_regfile_top.sv
test/clk_gen.sv
test/tb_tmr_regfile.sv

/* test/clk_gen.sv */
// clk_gen: free running testbench clock
`timescale 1ns/100ps

module clk_gen #(
    parameter real PERIOD = 40.0
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2.0) clk_o = ~clk_o;  // half period toggle
        end
    end

endmodule

/* test/tb_tmr_regfile.sv */
// tb_tmr_regfile: random stimulus, copy-level reference model and checks for the TMR register file
`timescale 1ns/100ps
`include "tmr_defines.svh"

module tb_tmr_regfile import tmr_pkg::*; ();

    localparam int DEPTH = `TMR_DEPTH;
    localparam int WQ    = `TMR_WQ_DEPTH;

    logic        s_c_i;
    logic        rst_n_i;
    logic        wr_valid_i;
    addr_t       wr_addr_i;
    word_t       wr_data_i;
    logic        wr_credit_o;
    addr_t       rd_addr_i;
    word_t       rd_data_o;
    logic        rd_err_o;
    logic        inj_en_i;
    addr_t       inj_addr_i;
    copy_t       inj_copy_i;
    logic        inj_dual_i;
    word_t       inj_mask_i;
    logic [15:0] corr_count_o;

    int      seed = 32'ha9f7;
    word_t   model [DEPTH][3];  // expected copies per word
    wr_req_t pending [$];       // pushed, not yet popped
    int      credits;
    int      pushes;
    int      pulses;
    int      corrections;       // scrubber fixes expected so far

    clk_gen #(.PERIOD(40.0)) u_clk (.clk_o(s_c_i));

    tmr_regfile_top tmr_regfile_top_i (.*);

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            fail_run($sformatf("Mismatch %s expected %0h actual %0h", name, exp, act));
        end
    endtask

    function automatic word_t majority(input word_t a, input word_t b, input word_t c);
        word_t y;
        for (int i = 0; i < `TMR_WIDTH; i++) begin
            y[i] = (a[i] + b[i] + c[i]) >= 2;  // two of three
        end
        return y;
    endfunction

    function automatic word_t voted(input int a);
        return majority(model[a][0], model[a][1], model[a][2]);
    endfunction

    // one clock, then track returned credits and commit popped writes
    task automatic tick();
        wr_req_t r;
        @(posedge s_c_i);
        #2;
        if (wr_credit_o) begin
            credits++;
            pulses++;
            if (pending.size() == 0) begin
                fail_run("credit returned with no write outstanding");
            end
            r = pending.pop_front();
            for (int c = 0; c < 3; c++) begin
                model[r.addr][c] = r.data;
            end
        end
        check_eq("credit_range", 1, (credits >= 0) && (credits <= WQ));
    endtask

    task automatic push_write(input addr_t a, input word_t d);
        wr_valid_i = 1'b1;
        wr_addr_i  = a;
        wr_data_i  = d;
        credits--;
        pushes++;
        pending.push_back('{addr: a, data: d});
    endtask

    task automatic inject(input addr_t a, input copy_t c, input logic dual, input word_t m);
        inj_en_i   = 1'b1;
        inj_addr_i = a;
        inj_copy_i = c;
        inj_dual_i = dual;
        inj_mask_i = m;
        model[a][c] ^= m;
        if (dual) begin
            model[a][(c + 1) % 3] ^= m;
        end
    endtask

    task automatic drain_writes();
        int k;
        wr_valid_i = 1'b0;
        for (k = 0; k < 50; k++) begin
            if (credits == WQ && pending.size() == 0) break;
            tick();
        end
        if (credits != WQ || pending.size() != 0) begin
            fail_run("timeout waiting for write credits to return");
        end
    endtask

    task automatic read_check(input string name, input addr_t a, input word_t exp, input logic err);
        rd_addr_i = a;
        tick();
        check_eq({name, "_data"}, exp, rd_data_o);
        check_eq({name, "_err"}, err, rd_err_o);
    endtask

    // waits for one correction while the word keeps reading as exp
    task automatic await_correction(input string name, input addr_t a, input word_t exp);
        int k;
        rd_addr_i = a;
        tick();  // injection edge
        inj_en_i = 1'b0;
        corrections++;
        for (k = 0; k < DEPTH + 1; k++) begin
            tick();
            check_eq({name, "_vote"}, exp, rd_data_o);
            check_eq({name, "_flag"}, 1, rd_err_o);  // copies disagree until the fix
            if (corr_count_o == corrections) break;
        end
        if (k == DEPTH + 1) fail_run("timeout waiting for scrubber correction");
        for (int c = 0; c < 3; c++) begin
            model[a][c] = exp;
        end
        tick();
        check_eq({name, "_count"}, corrections, corr_count_o);
        read_check({name, "_after"}, a, exp, 1'b0);
    endtask

    initial begin
        int    idx;
        int    guard;
        addr_t a;
        word_t m;
        word_t exp;

        rst_n_i = 1'b0;
        wr_valid_i = 1'b0;
        wr_addr_i = '0;
        wr_data_i = '0;
        rd_addr_i = '0;
        inj_en_i = 1'b0;
        inj_addr_i = '0;
        inj_copy_i = '0;
        inj_dual_i = 1'b0;
        inj_mask_i = '0;
        credits = WQ;
        pushes = 0;
        pulses = 0;
        corrections = 0;
        for (int i = 0; i < DEPTH; i++) begin
            for (int c = 0; c < 3; c++) begin
                model[i][c] = word_t'(`TMR_RST_VAL);
            end
        end
        repeat (3) @(posedge s_c_i);
        #2 rst_n_i = 1'b1;

        // reset state
        check_eq("reset_corr_count", 0, corr_count_o);
        for (int i = 0; i < DEPTH; i++) begin
            read_check("reset_read", addr_t'(i), word_t'(`TMR_RST_VAL), 1'b0);
        end

        // one random write per address within the credit limit
        idx = 0;
        for (guard = 0; guard < 200 && idx < DEPTH; guard++) begin
            wr_valid_i = 1'b0;
            if (credits > 0 && $random(seed) % 2 == 0) begin
                push_write(addr_t'(idx), word_t'($random(seed)));
                idx++;
            end
            tick();
        end
        if (idx < DEPTH) fail_run("timeout sending the write sequence");
        drain_writes();
        check_eq("write_pulses", pushes, pulses);
        for (int i = 0; i < DEPTH; i++) begin
            read_check("write_read", addr_t'(i), voted(i), 1'b0);
        end

        // single copy upset is outvoted, then scrubbed
        a = addr_t'($random(seed));
        exp = voted(a);
        inject(a, copy_t'({$random(seed)} % 3), 1'b0, word_t'($random(seed)) | 1);
        await_correction("single_inj", a, exp);

        // two copies hit, the majority becomes the flipped word
        a = addr_t'($random(seed));
        m = word_t'($random(seed)) | 1;
        exp = voted(a) ^ m;
        inject(a, copy_t'({$random(seed)} % 3), 1'b1, m);
        await_correction("dual_inj", a, exp);
        repeat (DEPTH) tick();
        read_check("dual_stable", a, exp, 1'b0);

        // writes to the lower half while the upper half keeps getting upsets
        pushes = 0;
        pulses = 0;
        for (int n = 0; n < 60; n++) begin
            wr_valid_i = 1'b0;
            inj_en_i = 1'b0;
            if (credits > 0 && $random(seed) % 4 != 0) begin
                push_write(addr_t'({$random(seed)} % (DEPTH / 2)), word_t'($random(seed)));
            end
            if ($random(seed) % 3 == 0) begin
                inject(addr_t'(DEPTH / 2 + {$random(seed)} % (DEPTH / 2)), 2'd0, 1'b0,
                       word_t'($random(seed)));
            end
            tick();
        end
        inj_en_i = 1'b0;
        drain_writes();
        check_eq("burst_pulses", pushes, pulses);
        repeat (DEPTH + 2) tick();  // let the scrubber finish a sweep
        for (int i = 0; i < DEPTH; i++) begin
            exp = voted(i);
            for (int c = 0; c < 3; c++) begin
                model[i][c] = exp;
            end
            read_check("burst_read", addr_t'(i), exp, 1'b0);
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule
